//--- design/cache_pkg.sv
// shared data types and miss FSM states for the two-port write-back cache
package cache_pkg;

  // one data word on every client, memory and storage path
  typedef logic [31:0] data_t;

  // byte enable for one data word
  typedef logic [3:0] be_t;

  // miss sequencer states
  typedef enum logic [1:0] {
    MS_IDLE      = 2'd0,
    MS_WRITEBACK = 2'd1, // dirty victim going out
    MS_REFILL    = 2'd2  // new line coming in
  } miss_state_e;

endpackage

//--- design/cache_line_store.sv
// tag, valid, dirty and word storage of the cache, two lookup ports plus refill/writeback access
`timescale 1ns/100ps

module cache_line_store import cache_pkg::*; #(
  parameter int ADDR_W   = 32,
  parameter int INDEX_W  = 4,
  parameter int OFFSET_W = 5
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  // port A lookup
  input  logic [INDEX_W-1:0]                     a_index_i,
  input  logic [OFFSET_W-3:0]                    a_word_i,
  input  logic [ADDR_W-INDEX_W-OFFSET_W-1:0]     a_tag_i,
  // port B lookup
  input  logic [INDEX_W-1:0]                     b_index_i,
  input  logic [OFFSET_W-3:0]                    b_word_i,
  input  logic [ADDR_W-INDEX_W-OFFSET_W-1:0]     b_tag_i,
  // merged write port
  input  logic                                   wr_en_i,
  input  logic [INDEX_W-1:0]                     wr_index_i,
  input  logic [OFFSET_W-3:0]                    wr_word_i,
  input  data_t                                  wr_data_i,
  input  be_t                                    wr_be_i,
  input  logic                                   wr_dirty_i,
  input  logic                                   wr_valid_i,
  input  logic [ADDR_W-INDEX_W-OFFSET_W-1:0]     wr_tag_i,
  // writeback read port
  input  logic [INDEX_W-1:0]                     wb_index_i,
  input  logic [OFFSET_W-3:0]                    wb_word_i,
  output data_t                                  a_data_o,
  output logic                                   a_hit_o,
  output logic                                   a_dirty_o,
  output logic [ADDR_W-INDEX_W-OFFSET_W-1:0]     a_tag_o,
  output data_t                                  b_data_o,
  output logic                                   b_hit_o,
  output data_t                                  wb_data_o
);

  localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;
  localparam int WORD_W     = OFFSET_W - 2;
  localparam int LINES      = 2 ** INDEX_W;
  localparam int LINE_WORDS = 2 ** WORD_W;

  logic [TAG_W-1:0] tag_q [LINES];
  logic [LINES-1:0] valid_q;
  logic [LINES-1:0] dirty_q;
  data_t            data_q [LINES*LINE_WORDS];

  // word storage and tags
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      for (int i = 0; i < 4; i++) begin
        if (wr_be_i[i]) begin
          data_q[{wr_index_i, wr_word_i}][8*i +: 8] <= wr_data_i[8*i +: 8];
        end
      end
      tag_q[wr_index_i] <= wr_tag_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (wr_en_i) begin
      valid_q[wr_index_i] <= wr_valid_i; // refill keeps line invalid until last beat
      dirty_q[wr_index_i] <= wr_dirty_i;
    end
  end

  assign a_data_o = data_q[{a_index_i, a_word_i}];
  assign a_hit_o  = valid_q[a_index_i] && (tag_q[a_index_i] == a_tag_i);

  assign b_data_o = data_q[{b_index_i, b_word_i}];
  assign b_hit_o  = valid_q[b_index_i] && (tag_q[b_index_i] == b_tag_i);

  // victim state for the miss FSM, read at the line under replacement
  assign a_dirty_o = dirty_q[wb_index_i];
  assign a_tag_o   = tag_q[wb_index_i];

  assign wb_data_o = data_q[{wb_index_i, wb_word_i}];

endmodule

//--- design/cache_port_front.sv
// client side of the cache: address split, hit/miss, waitrequests and port A hit write enable
`timescale 1ns/100ps

module cache_port_front import cache_pkg::*; #(
  parameter int ADDR_W   = 32,
  parameter int INDEX_W  = 4,
  parameter int OFFSET_W = 5
) (
  input  logic [ADDR_W-1:0]                      a_addr_i,
  input  logic                                   a_read_i,
  input  logic                                   a_write_i,
  input  be_t                                    a_be_i,
  input  logic [ADDR_W-1:0]                      b_addr_i,
  input  logic                                   b_read_i,
  input  logic                                   a_hit_i,
  input  logic                                   b_hit_i,
  input  logic                                   busy_i,
  input  logic [INDEX_W-1:0]                     miss_index_i,
  output logic                                   a_wait_o,
  output logic                                   b_wait_o,
  output logic                                   a_miss_o,
  output logic                                   b_miss_o,
  output logic [INDEX_W-1:0]                     a_index_o,
  output logic [OFFSET_W-3:0]                    a_word_o,
  output logic [ADDR_W-INDEX_W-OFFSET_W-1:0]     a_tag_o,
  output logic [INDEX_W-1:0]                     b_index_o,
  output logic [OFFSET_W-3:0]                    b_word_o,
  output logic [ADDR_W-INDEX_W-OFFSET_W-1:0]     b_tag_o,
  output logic                                   hit_we_o
);

  logic a_req;
  logic same_idx_read; // port B reading the line port A wants to write
  logic line_busy;     // port A touching the line under replacement
  logic a_stall;

  // byte offset bits [1:0] are not part of the word select
  assign {a_tag_o, a_index_o, a_word_o} = a_addr_i[ADDR_W-1:2];
  assign {b_tag_o, b_index_o, b_word_o} = b_addr_i[ADDR_W-1:2];

  assign a_req    = a_read_i || a_write_i;
  assign a_miss_o = a_req && !a_hit_i;
  assign b_miss_o = b_read_i && !b_hit_i;

  assign same_idx_read = b_read_i && (a_index_o == b_index_o);
  assign line_busy     = a_req && busy_i && (a_index_o == miss_index_i);

  // the store write port belongs to the burst while a miss runs
  assign a_stall = (a_write_i && (same_idx_read || busy_i)) || line_busy;

  assign a_wait_o = a_miss_o || a_stall;
  assign b_wait_o = b_miss_o;

  assign hit_we_o = a_write_i && a_hit_i && !a_stall && (|a_be_i);

endmodule

//--- design/cache_burst_engine.sv
// memory port datapath: burst address, read/write strobes and beat counting for refill and writeback
`timescale 1ns/100ps

module cache_burst_engine #(
  parameter int ADDR_W   = 32,
  parameter int OFFSET_W = 5
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start_wb_i,
  input  logic                  start_refill_i,
  input  logic [ADDR_W-1:0]     wb_addr_i,
  input  logic [ADDR_W-1:0]     refill_addr_i,
  input  logic                  m_wait_i,
  input  logic                  m_rvalid_i,
  output logic [ADDR_W-1:0]     m_addr_o,
  output logic [OFFSET_W-2:0]   m_burstcount_o,
  output logic                  m_read_o,
  output logic                  m_write_o,
  output logic [OFFSET_W-3:0]   beat_word_o,
  output logic                  refill_we_o,
  output logic                  last_beat_o,
  output logic                  burst_done_o
);

  localparam int WORD_W     = OFFSET_W - 2;
  localparam int LINE_WORDS = 2 ** WORD_W;
  localparam logic [OFFSET_W-2:0] BURST_LEN = (OFFSET_W-1)'(LINE_WORDS);

  logic [ADDR_W-1:0] addr_q;
  logic              read_q;
  logic              write_q;
  logic              rd_pend_q; // read beats still expected
  logic [WORD_W-1:0] beat_q;
  logic              wr_accept;

  assign wr_accept   = write_q && !m_wait_i;
  assign refill_we_o = rd_pend_q && m_rvalid_i;
  assign last_beat_o = &beat_q;
  assign burst_done_o = (wr_accept || refill_we_o) && last_beat_o;

  // line aligned, held for the whole burst
  always_ff @(posedge clk) begin
    if (start_wb_i) begin
      addr_q <= {wb_addr_i[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    end else if (start_refill_i) begin
      addr_q <= {refill_addr_i[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      read_q    <= 1'b0;
      write_q   <= 1'b0;
      rd_pend_q <= 1'b0;
      beat_q    <= '0;
    end else begin
      if (read_q && !m_wait_i) begin
        read_q <= 1'b0; // command taken, beats follow
      end
      if (wr_accept || refill_we_o) begin
        beat_q <= beat_q + 1'b1;
      end
      if (wr_accept && last_beat_o) begin
        write_q <= 1'b0;
      end
      if (refill_we_o && last_beat_o) begin
        rd_pend_q <= 1'b0;
      end
      if (start_wb_i) begin
        write_q <= 1'b1;
        beat_q  <= '0;
      end
      if (start_refill_i) begin
        read_q    <= 1'b1;
        rd_pend_q <= 1'b1;
        beat_q    <= '0;
      end
    end
  end

  assign m_addr_o       = addr_q;
  assign m_burstcount_o = BURST_LEN;
  assign m_read_o       = read_q;
  assign m_write_o      = write_q;
  assign beat_word_o    = beat_q;

endmodule

//--- design/cache_miss_ctrl.sv
// miss FSM: picks the missing port, latches its address and runs writeback then refill
`timescale 1ns/100ps

module cache_miss_ctrl import cache_pkg::*; #(
  parameter int ADDR_W   = 32,
  parameter int INDEX_W  = 4,
  parameter int OFFSET_W = 5
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   a_miss_i,
  input  logic                                   b_miss_i,
  input  logic [ADDR_W-1:0]                      a_addr_i,
  input  logic [ADDR_W-1:0]                      b_addr_i,
  input  logic                                   victim_dirty_i,
  input  logic [ADDR_W-INDEX_W-OFFSET_W-1:0]     victim_tag_i,
  input  logic                                   burst_done_i,
  output logic                                   busy_o,
  output logic [INDEX_W-1:0]                     miss_index_o,
  output logic                                   start_wb_o,
  output logic                                   start_refill_o,
  output logic [ADDR_W-1:0]                      wb_addr_o,
  output logic [ADDR_W-1:0]                      refill_addr_o
);

  miss_state_e       state_q;
  miss_state_e       state_d;
  logic [ADDR_W-1:0] addr_q;   // address of the miss being serviced
  logic [ADDR_W-1:0] sel_addr;
  logic [ADDR_W-1:0] cur_addr;
  logic              any_miss;

  assign any_miss = a_miss_i || b_miss_i;
  assign sel_addr = a_miss_i ? a_addr_i : b_addr_i; // port A wins

  // live in idle so the victim lookup is ready in the miss cycle
  assign cur_addr     = (state_q == MS_IDLE) ? sel_addr : addr_q;
  assign miss_index_o = cur_addr[OFFSET_W +: INDEX_W];

  always_comb begin
    state_d = state_q;
    case (state_q)
      MS_IDLE: begin
        if (any_miss) begin
          state_d = victim_dirty_i ? MS_WRITEBACK : MS_REFILL;
        end
      end
      MS_WRITEBACK: begin
        if (burst_done_i) begin
          state_d = MS_REFILL;
        end
      end
      MS_REFILL: begin
        if (burst_done_i) begin
          state_d = MS_IDLE;
        end
      end
      default: state_d = MS_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == MS_IDLE && any_miss) begin
      addr_q <= sel_addr;
    end
  end

  assign busy_o     = (state_q != MS_IDLE);
  assign start_wb_o = (state_q == MS_IDLE) && any_miss && victim_dirty_i;
  assign start_refill_o = ((state_q == MS_IDLE) && any_miss && !victim_dirty_i) ||
                          ((state_q == MS_WRITEBACK) && burst_done_i);

  assign wb_addr_o     = {victim_tag_i, miss_index_o, {OFFSET_W{1'b0}}};
  assign refill_addr_o = cur_addr; // engine drops the offset

endmodule

//--- design/cache_top.sv
// two-port write-back cache top level, connects store, client front, miss FSM and burst engine
`timescale 1ns/100ps

module cache_top import cache_pkg::*; #(
  parameter int ADDR_W   = 32,
  parameter int INDEX_W  = 4,
  parameter int OFFSET_W = 5
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [ADDR_W-1:0]     a_addr_i,
  input  logic                  a_read_i,
  input  logic                  a_write_i,
  input  data_t                 a_wdata_i,
  input  be_t                   a_be_i,
  output data_t                 a_rdata_o,
  output logic                  a_wait_o,
  input  logic [ADDR_W-1:0]     b_addr_i,
  input  logic                  b_read_i,
  output data_t                 b_rdata_o,
  output logic                  b_wait_o,
  output logic [ADDR_W-1:0]     m_addr_o,
  output logic [OFFSET_W-2:0]   m_burstcount_o,
  output logic                  m_read_o,
  output logic                  m_write_o,
  output data_t                 m_wdata_o,
  input  data_t                 m_rdata_i,
  input  logic                  m_wait_i,
  input  logic                  m_rvalid_i
);

  localparam int TAG_W  = ADDR_W - INDEX_W - OFFSET_W;
  localparam int WORD_W = OFFSET_W - 2;

  logic [INDEX_W-1:0] a_index, b_index, miss_index, wr_index;
  logic [WORD_W-1:0]  a_word, b_word, beat_word, wr_word;
  logic [TAG_W-1:0]   a_tag, b_tag, victim_tag, wr_tag;
  logic               a_hit, b_hit, a_miss, b_miss, victim_dirty;
  logic               hit_we, refill_we, last_beat, burst_done, busy;
  logic               start_wb, start_refill;
  logic [ADDR_W-1:0]  wb_addr, refill_addr;
  logic               wr_en, wr_dirty, wr_valid;
  data_t              wr_data;
  be_t                wr_be;

  // hit writes and refill beats never overlap, refill only runs while busy
  assign wr_en    = hit_we || refill_we;
  assign wr_index = refill_we ? miss_index : a_index;
  assign wr_word  = refill_we ? beat_word : a_word;
  assign wr_data  = refill_we ? m_rdata_i : a_wdata_i;
  assign wr_be    = refill_we ? 4'hf : a_be_i;
  assign wr_dirty = !refill_we;
  assign wr_valid = refill_we ? last_beat : 1'b1;
  assign wr_tag   = refill_we ? refill_addr[ADDR_W-1 -: TAG_W] : a_tag;

  cache_line_store #(.ADDR_W(ADDR_W), .INDEX_W(INDEX_W), .OFFSET_W(OFFSET_W)) u_store (
    .clk(clk), .rst_n(rst_n),
    .a_index_i(a_index), .a_word_i(a_word), .a_tag_i(a_tag),
    .b_index_i(b_index), .b_word_i(b_word), .b_tag_i(b_tag),
    .wr_en_i(wr_en), .wr_index_i(wr_index), .wr_word_i(wr_word),
    .wr_data_i(wr_data), .wr_be_i(wr_be), .wr_dirty_i(wr_dirty),
    .wr_valid_i(wr_valid), .wr_tag_i(wr_tag),
    .wb_index_i(miss_index), .wb_word_i(beat_word),
    .a_data_o(a_rdata_o), .a_hit_o(a_hit), .a_dirty_o(victim_dirty), .a_tag_o(victim_tag),
    .b_data_o(b_rdata_o), .b_hit_o(b_hit), .wb_data_o(m_wdata_o)
  );

  cache_port_front #(.ADDR_W(ADDR_W), .INDEX_W(INDEX_W), .OFFSET_W(OFFSET_W)) u_front (
    .a_addr_i(a_addr_i), .a_read_i(a_read_i), .a_write_i(a_write_i), .a_be_i(a_be_i),
    .b_addr_i(b_addr_i), .b_read_i(b_read_i), .a_hit_i(a_hit), .b_hit_i(b_hit),
    .busy_i(busy), .miss_index_i(miss_index),
    .a_wait_o(a_wait_o), .b_wait_o(b_wait_o), .a_miss_o(a_miss), .b_miss_o(b_miss),
    .a_index_o(a_index), .a_word_o(a_word), .a_tag_o(a_tag),
    .b_index_o(b_index), .b_word_o(b_word), .b_tag_o(b_tag),
    .hit_we_o(hit_we)
  );

  cache_miss_ctrl #(.ADDR_W(ADDR_W), .INDEX_W(INDEX_W), .OFFSET_W(OFFSET_W)) u_ctrl (
    .clk(clk), .rst_n(rst_n),
    .a_miss_i(a_miss), .b_miss_i(b_miss), .a_addr_i(a_addr_i), .b_addr_i(b_addr_i),
    .victim_dirty_i(victim_dirty), .victim_tag_i(victim_tag), .burst_done_i(burst_done),
    .busy_o(busy), .miss_index_o(miss_index),
    .start_wb_o(start_wb), .start_refill_o(start_refill),
    .wb_addr_o(wb_addr), .refill_addr_o(refill_addr)
  );

  cache_burst_engine #(.ADDR_W(ADDR_W), .OFFSET_W(OFFSET_W)) u_engine (
    .clk(clk), .rst_n(rst_n),
    .start_wb_i(start_wb), .start_refill_i(start_refill),
    .wb_addr_i(wb_addr), .refill_addr_i(refill_addr),
    .m_wait_i(m_wait_i), .m_rvalid_i(m_rvalid_i),
    .m_addr_o(m_addr_o), .m_burstcount_o(m_burstcount_o),
    .m_read_o(m_read_o), .m_write_o(m_write_o),
    .beat_word_o(beat_word), .refill_we_o(refill_we),
    .last_beat_o(last_beat), .burst_done_o(burst_done)
  );

endmodule

//--- verif/cache_asserts.sv
// memory port protocol assertions, bound into the cache top level for every simulation
`timescale 1ns/100ps

module cache_asserts import cache_pkg::*; #(
  parameter int ADDR_W = 32
) (
  input logic              clk,
  input logic              rst_n,
  input logic              m_read_i,
  input logic              m_write_i,
  input logic              m_wait_i,
  input logic [ADDR_W-1:0] m_addr_i,
  input data_t             m_wdata_i
);

  // one burst direction at a time
  assert property (@(posedge clk) disable iff (!rst_n) !(m_read_i && m_write_i))
    else $error("memory read and write strobes high together");

  assert property (@(posedge clk) disable iff (!rst_n)
    (m_read_i && m_wait_i) |=> (m_read_i && $stable(m_addr_i)))
    else $error("read command dropped or moved while memory wait was high");

  // write data held until the beat is taken
  assert property (@(posedge clk) disable iff (!rst_n)
    (m_write_i && m_wait_i) |=> (m_write_i && $stable(m_addr_i) && $stable(m_wdata_i)))
    else $error("write beat dropped or changed while memory wait was high");

  assert property (@(posedge clk) !rst_n |-> !(m_read_i || m_write_i))
    else $error("memory strobe high during reset");

endmodule

bind cache_top cache_asserts #(.ADDR_W(ADDR_W)) u_asserts (
  .clk(clk), .rst_n(rst_n), .m_read_i(m_read_o), .m_write_i(m_write_o),
  .m_wait_i(m_wait_i), .m_addr_i(m_addr_o), .m_wdata_i(m_wdata_o)
);

//--- verif/cache_tb.sv
// simulation top that drives random client and burst memory traffic into the cache and checks every result
`timescale 1ns/100ps

module cache_tb import cache_pkg::*; ();

  localparam int LINE_WORDS   = 8;
  localparam int MEM_WORDS    = 512; // 2 tag bits, 4 index bits, 3 word bits
  localparam int NUM_OPS      = 600;
  localparam int RESET_CYCLES = 3;
  localparam int MISS_CYCLES  = 120; // writeback plus refill under heavy wait
  localparam int WATCHDOG_NS  = (RESET_CYCLES + 2 * MISS_CYCLES * NUM_OPS) * 10;

  logic        clk, rst_n;
  logic [31:0] a_addr, b_addr, m_addr;
  logic        a_read, a_write, a_wait, b_read, b_wait;
  data_t       a_wdata, a_rdata, b_rdata, m_wdata, m_rdata;
  be_t         a_be;
  logic [3:0]  m_burstcount;
  logic        m_read, m_write, m_wait, m_rvalid;

  data_t       mem [MEM_WORDS];    // backing store behind the memory port
  data_t       golden [MEM_WORDS];
  logic [63:0] line_loaded;        // lines fetched by a read burst so far
  logic [63:0] line_dirty;         // lines with client writes not yet in memory
  logic [31:0] lfsr;
  logic [5:0]  rd_line;
  logic [2:0]  rd_beat, wr_beat;
  int          rd_left, a_waited, conflicts;
  logic        a_pend, b_pend, conflict;

  cache_top #(.ADDR_W(32), .INDEX_W(4), .OFFSET_W(5)) dut (
    .clk(clk), .rst_n(rst_n),
    .a_addr_i(a_addr), .a_read_i(a_read), .a_write_i(a_write), .a_wdata_i(a_wdata),
    .a_be_i(a_be), .a_rdata_o(a_rdata), .a_wait_o(a_wait),
    .b_addr_i(b_addr), .b_read_i(b_read), .b_rdata_o(b_rdata), .b_wait_o(b_wait),
    .m_addr_o(m_addr), .m_burstcount_o(m_burstcount), .m_read_o(m_read), .m_write_o(m_write),
    .m_wdata_o(m_wdata), .m_rdata_i(m_rdata), .m_wait_i(m_wait), .m_rvalid_i(m_rvalid)
  );

  always #5 clk = ~clk;

  task automatic finish_failed();
    $display("test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    finish_failed();
  endtask

  task automatic report_error(input string msg);
    $display("ERROR %s", msg);
    finish_failed();
  endtask

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input be_t be);
    data_t mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  task automatic sample_outputs();
    logic [8:0] widx;
    if (!rst_n) begin
      assert (!m_read && !m_write) else report_error("memory strobe high during reset");
    end
    assert (a_pend || !a_wait) else report_mismatch("a_wait_o", 32'(a_wait), 32'd0);
    assert (b_pend || !b_wait) else report_mismatch("b_wait_o", 32'(b_wait), 32'd0);
    if (a_pend && !a_wait) begin
      widx = a_addr[10:2];
      assert (line_loaded[a_addr[10:5]]) else report_error("port A done on a line never fetched");
      if (a_write) begin
        assert (!conflict || a_waited > 0)
          else report_error("port A write did not wait for the same index port B read");
        golden[widx] = merge_bytes(golden[widx], a_wdata, a_be);
        line_dirty[a_addr[10:5]] = 1'b1;
      end else begin
        assert (a_rdata == golden[widx]) else report_mismatch("a_rdata_o", a_rdata, golden[widx]);
      end
      a_pend = 1'b0;
    end else if (a_pend) begin
      a_waited++;
    end
    if (b_pend && !b_wait) begin
      widx = b_addr[10:2];
      assert (line_loaded[b_addr[10:5]]) else report_error("port B done on a line never fetched");
      assert (b_rdata == golden[widx]) else report_mismatch("b_rdata_o", b_rdata, golden[widx]);
      b_pend = 1'b0;
    end
    if (m_read || m_write) begin
      assert (m_addr[4:0] == 5'd0) else report_mismatch("m_addr_o", m_addr, {m_addr[31:5], 5'd0});
      assert (32'(m_burstcount) == LINE_WORDS)
        else report_mismatch("m_burstcount_o", 32'(m_burstcount), LINE_WORDS);
    end
    if (m_write && !m_wait) begin
      widx = {m_addr[10:5], wr_beat};
      assert (line_dirty[m_addr[10:5]]) else report_error("clean line written back to memory");
      assert (m_wdata == golden[widx]) else report_mismatch("m_wdata_o", m_wdata, golden[widx]);
      mem[widx] = m_wdata;
      if (wr_beat == 3'd7) begin
        line_dirty[m_addr[10:5]] = 1'b0; // whole line now in memory
      end
      wr_beat = wr_beat + 3'd1;
    end
    if (m_rvalid) begin
      rd_beat = rd_beat + 3'd1;
      rd_left--;
    end
    if (m_read && !m_wait) begin
      assert (rd_left == 0) else report_error("read burst issued before the last one finished");
      rd_line = m_addr[10:5];
      rd_beat = 3'd0;
      rd_left = LINE_WORDS;
      line_loaded[m_addr[10:5]] = 1'b1;
      line_dirty[m_addr[10:5]] = 1'b0; // fresh copy from memory
    end
  endtask

  task automatic drive_memory();
    logic [31:0] r;
    rand_bits(2, r);
    m_wait = (r[1:0] == 2'd0); // one cycle in four
    rand_bits(2, r);
    m_rvalid = (rd_left > 0) && (r[1:0] != 2'd0);
    m_rdata = m_rvalid ? mem[{rd_line, rd_beat}] : '0;
  endtask

  task automatic run_cycle();
    @(negedge clk);
    sample_outputs();
    @(posedge clk);
    #1;
    drive_memory();
  endtask

  initial begin
    #(WATCHDOG_NS);
    report_error("watchdog expired before all operations completed");
  end

  initial begin
    logic [31:0] r;
    logic [1:0]  kind;
    clk = 1'b0;
    rst_n = 1'b0;
    a_addr = '0;
    a_read = 1'b0;
    a_write = 1'b0;
    a_wdata = '0;
    a_be = '0;
    b_addr = '0;
    b_read = 1'b0;
    m_rdata = '0;
    m_wait = 1'b0;
    m_rvalid = 1'b0;
    lfsr = 32'hec18_7bef;
    line_loaded = '0;
    line_dirty = '0;
    rd_line = '0;
    rd_beat = '0;
    wr_beat = '0;
    rd_left = 0;
    conflicts = 0;
    a_pend = 1'b0;
    b_pend = 1'b0;
    conflict = 1'b0;
    a_waited = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = 32'h1357_9bdf ^ (i * 32'h9e37_79b9);
      golden[i] = mem[i];
    end
    repeat (RESET_CYCLES) run_cycle();
    rst_n = 1'b1;
    run_cycle();
    assert (!m_read && !m_write) else report_error("memory strobe high after reset");
    for (int n = 0; n < NUM_OPS; n++) begin
      rand_bits(2, r);
      kind = r[1:0];
      rand_bits(9, r);
      a_addr = {21'd0, r[8:0], 2'b00};
      rand_bits(10, r);
      b_addr = {21'd0, r[8:0], 2'b00};
      if (r[9]) begin
        b_addr[8:5] = a_addr[8:5]; // same line index as port A
      end
      rand_bits(1, r);
      b_read = r[0] || (kind == 2'd0);
      rand_bits(32, r);
      a_wdata = r;
      rand_bits(4, r);
      a_be = r[3:0];
      a_read = (kind == 2'd1);
      a_write = kind[1];
      a_pend = (kind != 2'd0);
      b_pend = b_read;
      a_waited = 0;
      conflict = a_write && b_read && (a_addr[8:5] == b_addr[8:5]);
      if (conflict) begin
        conflicts++;
      end
      while (a_pend || b_pend) begin
        run_cycle();
        if (!a_pend) begin
          a_read = 1'b0;
          a_write = 1'b0;
        end
        if (!b_pend) begin
          b_read = 1'b0;
        end
      end
    end
    if (conflicts > 0) begin
      $display("test passed");
      $finish;
    end else begin
      report_error("no same index write and read pair was generated");
    end
  end

endmodule

//--- all.f
design/cache_pkg.sv
design/cache_line_store.sv
design/cache_port_front.sv
design/cache_burst_engine.sv
design/cache_miss_ctrl.sv
design/cache_top.sv
verif/cache_asserts.sv
verif/cache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module cache_tb --Mdir obj_dir -f all.f || exit 1
out=$(./obj_dir/Vcache_tb 2>&1)
echo "$out"
echo "$out" | grep -qx "test passed" && exit 0 || exit 1
